// File: pe_conv.f
+incdir+.
pe_data_pkg.sv
pe_ctrl_pkg.sv
pe_scratch.sv
pe_spad_loader.sv
pe_read_addr_gen.sv
pe_mac_accum.sv
pe_conv_top.sv
tb_pe_conv.sv

// File: tb_pe_conv.sv
`timescale 1ns/1ps
`include "pe_conv_params.svh"

module tb_pe_conv
    import pe_data_pkg::*, pe_ctrl_pkg::*;
();

    logic           clk = 1'b0;
    logic           rst_n = 1'b0;
    logic           start = 1'b0;
    pe_cfg_t        cfg = '0;
    logic           if_buf_empty = 1'b1;
    if_fifo_entry_t if_fifo_entry = '0;
    logic           if_buf_read;
    logic           filt_buf_empty = 1'b1;
    weight_t        filt_data = '0;
    logic           filt_buf_read;
    logic           psum_buf_empty = 1'b1;
    acc_t           psum_data = '0;
    logic           psum_buf_read;
    logic           outbuf_full = 1'b0;
    acc_t           out_data;
    logic           outbuf_write;
    logic           done;

    // FIFO models and the expected output stream
    if_fifo_entry_t if_q[$];
    weight_t        filt_q[$];
    acc_t           psum_q[$];
    acc_t           exp_q[$];

    logic [31:0] data_seed = 32'h55;
    logic [31:0] gap_seed = 32'h55;
    logic [5:0]  gap_lvl = 6'd0;
    logic        running = 1'b0;
    logic        cur_psum = 1'b0;
    int          errs = 0;
    int          out_cnt = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    int          limit = 100;

    pe_conv_top pe_conv_top_i (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic value_error(input string msg);
        errs++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task automatic protocol_error(input string msg);
        errs++;
        $display("Failure at %0t ns: %s", $time, msg);
    endtask

    task automatic report_test(input string name, input int errs_before, input int n_out);
        tests_run++;
        if (errs == errs_before) begin
            $display("%s: pass, %0d outputs", name, n_out);
        end else begin
            tests_failed++;
            $display("%s: FAIL, %0d errors", name, errs - errs_before);
        end
    endtask

    // Run length bound grows with every test that is started
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: the DUT did not finish within %0d cycles", limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Show-ahead FIFOs, output buffer and checks on every edge
    always @(posedge clk) begin : fifo_model
        if (rst_n) begin
            if (!running && (outbuf_write || done || if_buf_read || filt_buf_read
                             || psum_buf_read))
                protocol_error("DUT output active while no run is in progress");
            if (if_buf_read) begin
                if (if_buf_empty || if_q.size() == 0)
                    protocol_error("ifmap FIFO read while empty");
                else
                    if_q.delete(0);
            end
            if (filt_buf_read) begin
                if (filt_buf_empty || filt_q.size() == 0)
                    protocol_error("filter FIFO read while empty");
                else
                    filt_q.delete(0);
            end
            if (psum_buf_read !== (outbuf_write && cur_psum))
                protocol_error("psum FIFO read not paired with an output write");
            if (psum_buf_read) begin
                if (psum_buf_empty || psum_q.size() == 0)
                    protocol_error("psum FIFO read while empty");
                else
                    psum_q.delete(0);
            end
            if (outbuf_write) begin
                if (outbuf_full)
                    protocol_error("output written while the output buffer is full");
                if (exp_q.size() == 0) begin
                    protocol_error("more outputs written than windows exist");
                end else begin
                    if (out_data !== exp_q[0])
                        value_error($sformatf("output %0d is %0h, expected %0h",
                                              out_cnt, out_data, exp_q[0]));
                    exp_q.delete(0);
                end
                out_cnt++;
            end
            if (done) begin
                if (exp_q.size() != 0)
                    protocol_error("done arrived before all outputs were written");
                running <= 1'b0;
            end
        end
        // Random gaps that show empty even while words remain
        gap_seed = lcg(gap_seed);
        if_buf_empty   <= (if_q.size() == 0) || (gap_seed[31:26] < gap_lvl);
        filt_buf_empty <= (filt_q.size() == 0) || (gap_seed[25:20] < gap_lvl);
        psum_buf_empty <= (psum_q.size() == 0) || (gap_seed[19:14] < gap_lvl);
        outbuf_full    <= gap_seed[13:8] < gap_lvl;
        if_fifo_entry  <= (if_q.size() != 0) ? if_q[0] : '0;
        filt_data      <= (filt_q.size() != 0) ? filt_q[0] : '0;
        psum_data      <= (psum_q.size() != 0) ? psum_q[0] : '0;
    end

    task automatic run_test(input string name, input int fl, input int st,
                            input bit ps, input int len);
        pe_cfg_t        c;
        if_word_t       ifm[$];
        weight_t        wts[$];
        if_fifo_entry_t e;
        acc_t           p;
        int             n_win;
        int             sum;
        int             errs_before;
        errs_before = errs;
        for (int i = 0; i < len; i++) begin
            data_seed = lcg(data_seed);
            e.data = data_seed[23:16];
            e.last = (i == len - 1);
            ifm.push_back(e.data);
            if_q.push_back(e);
        end
        for (int t = 0; t < fl; t++) begin
            data_seed = lcg(data_seed);
            wts.push_back(data_seed[23:16]);
            filt_q.push_back(data_seed[23:16]);
        end
        // Only whole windows count and each starts one stride further on
        n_win = (len >= fl) ? (len - fl) / st + 1 : 0;
        for (int w = 0; w < n_win; w++) begin
            sum = 0;
            for (int t = 0; t < fl; t++)
                sum += wts[t] * ifm[w * st + t];
            if (ps) begin
                data_seed = lcg(data_seed);
                p = data_seed[31:8];
                psum_q.push_back(p);
                sum += p;
            end
            exp_q.push_back(acc_t'(sum));
        end
        c.filt_len = fl;
        c.stride   = st;
        c.acc_psum = ps;
        limit    <= limit + 20 * (n_win * fl + len + fl);
        cur_psum <= ps;
        out_cnt = 0;
        @(posedge clk);
        start   <= 1'b1;
        cfg     <= c;
        running <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (running)
            @(posedge clk);
        if (out_cnt != n_win)
            value_error($sformatf("%s gave %0d outputs, expected %0d", name, out_cnt, n_win));
        if (if_q.size() != 0 || filt_q.size() != 0 || psum_q.size() != 0)
            protocol_error("FIFO words left over after done");
        exp_q.delete();
        report_test(name, errs_before, n_win);
    endtask

    initial begin
        int errs_before;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        // Words wait in every FIFO but nothing may move before the first start
        errs_before = errs;
        for (int i = 0; i < 4; i++) begin
            if_q.push_back('0);
            filt_q.push_back('0);
            psum_q.push_back('0);
        end
        repeat (20) @(posedge clk);
        if_q.delete();
        filt_q.delete();
        psum_q.delete();
        report_test("idle after reset", errs_before, 0);
        for (int k = 0; k < 4; k++) begin
            data_seed = lcg(data_seed);
            run_test("stride 1", data_seed[18:16] + 1, 1, 1'b0, data_seed[28:24] + 1);
        end
        run_test("stride 2, odd length", 3, 2, 1'b0, 11);
        run_test("stride 3", 4, 3, 1'b0, 20);
        run_test("stride 4", 2, 4, 1'b0, 13);
        run_test("ifmap shorter than filter", 5, 2, 1'b0, 3);
        run_test("psum stride 1", 3, 1, 1'b1, 10);
        run_test("psum stride 2", 4, 2, 1'b1, 17);
        // Heavy back-pressure and gaps on every FIFO
        gap_lvl <= 6'd24;
        run_test("gaps, full filter and ifmap", 8, 1, 1'b1, 32);
        for (int k = 0; k < 4; k++) begin
            data_seed = lcg(data_seed);
            run_test("gaps, random", data_seed[18:16] + 1, data_seed[10:9] + 1,
                     data_seed[12], data_seed[28:24] + 1);
        end
        gap_lvl <= 6'd0;
        run_test("back to back, first", 6, 1, 1'b1, 24);
        run_test("back to back, second", 2, 3, 1'b0, 9);
        $display("Tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && errs == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: pe_conv_top.sv
`timescale 1ns/1ps
`include "pe_conv_params.svh"

module pe_conv_top
    import pe_data_pkg::*, pe_ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  pe_cfg_t        cfg,
    input  logic           if_buf_empty,
    input  if_fifo_entry_t if_fifo_entry,
    output logic           if_buf_read,
    input  logic           filt_buf_empty,
    input  weight_t        filt_data,
    output logic           filt_buf_read,
    input  logic           psum_buf_empty,
    input  acc_t           psum_data,
    output logic           psum_buf_read,
    input  logic           outbuf_full,
    output acc_t           out_data,
    output logic           outbuf_write,
    output logic           done
);

    logic                   if_wen;
    logic [`PE_IF_AW-1:0]   if_waddr;
    if_word_t               if_wdata;
    logic                   filt_wen;
    logic [`PE_FILT_AW-1:0] filt_waddr;
    weight_t                filt_wdata;
    logic                   loaded;
    logic [`PE_IF_AW:0]     if_len;
    pe_cfg_t                cfg_q;
    tap_cmd_t               cmd;
    logic                   cmd_valid;
    logic                   tap_first;
    logic                   tap_last;
    logic                   tap_valid;
    logic                   all_issued;
    logic                   stall;
    if_word_t               if_rdata;
    weight_t                filt_rdata;

    pe_spad_loader loader_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .cfg           (cfg),
        .if_buf_empty  (if_buf_empty),
        .if_fifo_entry (if_fifo_entry),
        .if_buf_read   (if_buf_read),
        .filt_buf_empty(filt_buf_empty),
        .filt_data     (filt_data),
        .filt_buf_read (filt_buf_read),
        .if_wen        (if_wen),
        .if_waddr      (if_waddr),
        .if_wdata      (if_wdata),
        .filt_wen      (filt_wen),
        .filt_waddr    (filt_waddr),
        .filt_wdata    (filt_wdata),
        .loaded        (loaded),
        .if_len        (if_len),
        .cfg_q         (cfg_q)
    );

    pe_scratch #(
        .entry_t(if_word_t),
        .DEPTH  (`PE_IF_DEPTH),
        .AW     (`PE_IF_AW)
    ) if_spad (
        .clk  (clk),
        .rst_n(rst_n),
        .wen  (if_wen),
        .waddr(if_waddr),
        .wdata(if_wdata),
        .raddr(cmd.if_raddr),
        .hold (stall),
        .rdata(if_rdata)
    );

    pe_scratch #(
        .entry_t(weight_t),
        .DEPTH  (`PE_FILT_DEPTH),
        .AW     (`PE_FILT_AW)
    ) filt_spad (
        .clk  (clk),
        .rst_n(rst_n),
        .wen  (filt_wen),
        .waddr(filt_waddr),
        .wdata(filt_wdata),
        .raddr(cmd.filt_raddr),
        .hold (stall),
        .rdata(filt_rdata)
    );

    pe_read_addr_gen addr_gen_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .loaded    (loaded),
        .if_len    (if_len),
        .cfg       (cfg_q),
        .stall     (stall),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .tap_first (tap_first),
        .tap_last  (tap_last),
        .tap_valid (tap_valid),
        .all_issued(all_issued)
    );

    pe_mac_accum mac_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .if_rdata      (if_rdata),
        .filt_rdata    (filt_rdata),
        .tap_first     (tap_first),
        .tap_last      (tap_last),
        .tap_valid     (tap_valid),
        .acc_psum      (cfg_q.acc_psum),
        .all_issued    (all_issued),
        .psum_buf_empty(psum_buf_empty),
        .psum_data     (psum_data),
        .psum_buf_read (psum_buf_read),
        .outbuf_full   (outbuf_full),
        .out_data      (out_data),
        .outbuf_write  (outbuf_write),
        .stall         (stall),
        .done          (done)
    );

endmodule

// File: pe_mac_accum.sv
`timescale 1ns/1ps
`include "pe_conv_params.svh"

module pe_mac_accum
    import pe_data_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  if_word_t if_rdata,
    input  weight_t  filt_rdata,
    input  logic     tap_first,
    input  logic     tap_last,
    input  logic     tap_valid,
    input  logic     acc_psum,
    input  logic     all_issued,
    input  logic     psum_buf_empty,
    input  acc_t     psum_data,
    output logic     psum_buf_read,
    input  logic     outbuf_full,
    output acc_t     out_data,
    output logic     outbuf_write,
    output logic     stall,
    output logic     done
);

    prod_t prod_q;
    logic  prod_first;
    logic  prod_last;
    logic  prod_valid;
    acc_t  acc_q;
    logic  out_valid;
    logic  done_seen;

    // Whole pipeline freezes on a full output buffer or a missing psum
    assign stall = outbuf_full || (acc_psum && psum_buf_empty);

    // Valid flags of the multiply and accumulate stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else if (!stall) begin
            prod_valid <= tap_valid;
            out_valid  <= prod_valid && prod_last;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            prod_q     <= if_rdata * filt_rdata;
            prod_first <= tap_first;
            prod_last  <= tap_last;
            // First tap of a window restarts the sum
            if (prod_valid) begin
                if (prod_first) begin
                    acc_q <= acc_t'(prod_q);
                end else begin
                    acc_q <= acc_q + acc_t'(prod_q);
                end
            end
        end
    end

    // Output stage, psum joins as the word leaves
    assign out_data      = acc_q + (acc_psum ? psum_data : '0);
    assign outbuf_write  = out_valid && !stall;
    assign psum_buf_read = outbuf_write && acc_psum;

    // One done per run once every stage has drained
    assign done = all_issued && !prod_valid && !out_valid && !done_seen;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_seen <= 1'b0;
        end else if (!all_issued) begin
            done_seen <= 1'b0;
        end else if (done) begin
            done_seen <= 1'b1;
        end
    end

endmodule

// File: pe_read_addr_gen.sv
`timescale 1ns/1ps
`include "pe_conv_params.svh"

module pe_read_addr_gen
    import pe_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               loaded,
    input  logic [`PE_IF_AW:0] if_len,
    input  pe_cfg_t            cfg,
    input  logic               stall,
    output tap_cmd_t           cmd,
    output logic               cmd_valid,
    output logic               tap_first,
    output logic               tap_last,
    output logic               tap_valid,
    output logic               all_issued
);

    localparam int XW = `PE_IF_AW + 2;

    logic [`PE_IF_AW:0]    base;
    logic [`PE_FILT_AW-1:0] tap;
    logic                  armed;
    logic                  last_tap;
    logic                  has_window;
    logic                  next_fits;
    logic [XW-1:0]         next_base;
    logic [XW-1:0]         filt_len_x;
    logic [XW-1:0]         if_len_x;

    // Widened copies so the window bound cannot overflow
    assign filt_len_x = {{(XW-`PE_FILT_AW-1){1'b0}}, cfg.filt_len};
    assign if_len_x   = {1'b0, if_len};
    assign next_base  = {1'b0, base} + {{(XW-3){1'b0}}, cfg.stride};

    assign last_tap   = ({1'b0, tap} == cfg.filt_len - 1'b1);
    assign has_window = (filt_len_x <= if_len_x);
    assign next_fits  = (next_base + filt_len_x <= if_len_x);

    always_comb begin
        cmd.if_raddr   = base[`PE_IF_AW-1:0] + {{(`PE_IF_AW-`PE_FILT_AW){1'b0}}, tap};
        cmd.filt_raddr = tap;
        cmd.first      = (tap == '0);
        cmd.last       = last_tap;
    end

    // Window base and tap walk
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
            base      <= '0;
            tap       <= '0;
            tap_valid <= 1'b0;
            armed     <= 1'b0;
        end else begin
            if (loaded) begin
                armed     <= 1'b1;
                cmd_valid <= has_window;
                base      <= '0;
                tap       <= '0;
            end else if (cmd_valid && !stall) begin
                if (last_tap) begin
                    tap <= '0;
                    if (next_fits) begin
                        base <= next_base[`PE_IF_AW:0];
                    end else begin
                        cmd_valid <= 1'b0;
                    end
                end else begin
                    tap <= tap + 1'b1;
                end
            end
            // Delay stage matches the scratchpad read latency
            if (!stall) begin
                tap_valid <= cmd_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            tap_first <= cmd.first;
            tap_last  <= cmd.last;
        end
    end

    // Low during loaded so a run with no windows still gives a fresh level
    assign all_issued = armed && !loaded && !cmd_valid && !tap_valid;

endmodule

// File: pe_spad_loader.sv
`timescale 1ns/1ps
`include "pe_conv_params.svh"

module pe_spad_loader
    import pe_data_pkg::*, pe_ctrl_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  pe_cfg_t                 cfg,
    input  logic                    if_buf_empty,
    input  if_fifo_entry_t          if_fifo_entry,
    output logic                    if_buf_read,
    input  logic                    filt_buf_empty,
    input  weight_t                 filt_data,
    output logic                    filt_buf_read,
    output logic                    if_wen,
    output logic [`PE_IF_AW-1:0]    if_waddr,
    output if_word_t                if_wdata,
    output logic                    filt_wen,
    output logic [`PE_FILT_AW-1:0]  filt_waddr,
    output weight_t                 filt_wdata,
    output logic                    loaded,
    output logic [`PE_IF_AW:0]      if_len,
    output pe_cfg_t                 cfg_q
);

    logic                  loading;
    logic                  if_done;
    logic                  filt_done;
    logic [`PE_IF_AW:0]    if_cnt;
    logic [`PE_FILT_AW:0]  filt_cnt;

    // Pop each stream whenever its FIFO has a word and it still needs one
    assign if_buf_read   = loading && !if_done && !if_buf_empty;
    assign filt_buf_read = loading && !filt_done && !filt_buf_empty;

    // Popped words go straight into the scratchpads
    assign if_wen     = if_buf_read;
    assign if_waddr   = if_cnt[`PE_IF_AW-1:0];
    assign if_wdata   = if_fifo_entry.data;
    assign filt_wen   = filt_buf_read;
    assign filt_waddr = filt_cnt[`PE_FILT_AW-1:0];
    assign filt_wdata = filt_data;

    // Single cycle, loading drops right after
    assign loaded = loading && if_done && filt_done;
    assign if_len = if_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            loading   <= 1'b0;
            if_done   <= 1'b0;
            filt_done <= 1'b0;
            if_cnt    <= '0;
            filt_cnt  <= '0;
            cfg_q     <= '0;
        end else if (start && !loading) begin
            loading   <= 1'b1;
            if_done   <= 1'b0;
            filt_done <= 1'b0;
            if_cnt    <= '0;
            filt_cnt  <= '0;
            cfg_q     <= cfg;
        end else if (loading) begin
            if (loaded) begin
                loading <= 1'b0;
            end
            // Ifmap stream ends on the end flag or a full scratchpad
            if (if_buf_read) begin
                if_cnt <= if_cnt + 1'b1;
                if (if_fifo_entry.last || if_cnt == `PE_IF_DEPTH - 1) begin
                    if_done <= 1'b1;
                end
            end
            // Filter stream ends after filt_len weights
            if (filt_buf_read) begin
                filt_cnt <= filt_cnt + 1'b1;
                if (filt_cnt == cfg_q.filt_len - 1'b1) begin
                    filt_done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: pe_scratch.sv
`timescale 1ns/1ps

module pe_scratch #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 8,
    parameter int  AW      = 3
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          wen,
    input  logic [AW-1:0] waddr,
    input  entry_t        wdata,
    input  logic [AW-1:0] raddr,
    input  logic          hold,
    output entry_t        rdata
);

    entry_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, frozen while the pipeline is stalled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (!hold) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: pe_ctrl_pkg.sv
`include "pe_conv_params.svh"

package pe_ctrl_pkg;

    // Run configuration, captured on start
    typedef struct packed {
        logic [`PE_FILT_AW:0] filt_len;
        logic [2:0]           stride;
        logic                 acc_psum;
    } pe_cfg_t;

    // One tap read, addresses both scratchpads
    typedef struct packed {
        logic [`PE_IF_AW-1:0]   if_raddr;
        logic [`PE_FILT_AW-1:0] filt_raddr;
        logic                   first;
        logic                   last;
    } tap_cmd_t;

endpackage

// File: pe_data_pkg.sv
`include "pe_conv_params.svh"

package pe_data_pkg;

    // One ifmap value and one filter weight
    typedef logic [`PE_DATA_W-1:0] if_word_t;
    typedef logic [`PE_DATA_W-1:0] weight_t;

    // Full-precision product of one tap
    typedef logic [2*`PE_DATA_W-1:0] prod_t;

    // Accumulator, partial sum and output word
    typedef logic [`PE_ACC_W-1:0] acc_t;

    // Head word of the ifmap FIFO, end flag above the data
    typedef struct packed {
        logic     last;
        if_word_t data;
    } if_fifo_entry_t;

endpackage

// File: pe_conv_params.svh
`ifndef PE_CONV_PARAMS_SVH
`define PE_CONV_PARAMS_SVH

// Data widths
`define PE_DATA_W 8
`define PE_ACC_W 24

// Scratchpad depths and matching address widths
`define PE_IF_DEPTH 32
`define PE_FILT_DEPTH 8
`define PE_IF_AW 5
`define PE_FILT_AW 3

`endif
